/* include/pcs_rx_macros.svh */
`ifndef PCS_RX_MACROS_SVH
`define PCS_RX_MACROS_SVH

// Datapath word and 64b66b payload widths
`define PCS_DATA_WIDTH 32
`define PCS_BLOCK_WIDTH 64

// Consecutive good headers needed for lock
`define PCS_LOCK_GOOD 64

// Bad headers within one 64 header window that drop lock
`define PCS_LOCK_BAD 16

`endif

/* logic/pcs_rx_pkg.sv */
`include "pcs_rx_macros.svh"

package pcs_rx_pkg;

    // Sync header codes as received on the line
    typedef logic [1:0] sync_header_t;

    localparam sync_header_t SYNC_DATA = 2'b01;
    localparam sync_header_t SYNC_CTRL = 2'b10;

    // Block type field of a control block
    typedef enum logic [7:0] {
        BT_IDLE = 8'h1E,
        BT_O4   = 8'h2D,
        BT_S4   = 8'h33,
        BT_O0S4 = 8'h66,
        BT_O0O4 = 8'h55,
        BT_S0   = 8'h78,
        BT_O0   = 8'h4B,
        BT_T0   = 8'h87,
        BT_T1   = 8'h99,
        BT_T2   = 8'hAA,
        BT_T3   = 8'hB4,
        BT_T4   = 8'hCC,
        BT_T5   = 8'hD2,
        BT_T6   = 8'hE1,
        BT_T7   = 8'hFF
    } block_type_t;

    // XGMII control characters
    localparam logic [7:0] RS_IDLE  = 8'h07;
    localparam logic [7:0] RS_START = 8'hFB;
    localparam logic [7:0] RS_TERM  = 8'hFD;
    localparam logic [7:0] RS_ERROR = 8'hFE;
    localparam logic [7:0] RS_SEQ   = 8'h9C;

    // 7-bit line control code to XGMII character
    function automatic logic [7:0] control_to_rs_code(input logic [6:0] code);
        return (code == 7'h00) ? RS_IDLE : RS_ERROR;
    endfunction

    // Ordered set O code to XGMII character
    function automatic logic [7:0] cc_to_rs_ocode(input logic [3:0] ocode);
        return (ocode == 4'h0) ? RS_SEQ : RS_ERROR;
    endfunction

    // Control view with lane n code sitting at bits 8+7n
    typedef struct packed {
        logic [`PCS_BLOCK_WIDTH/8-1:0][6:0] codes;
        block_type_t                        btype;
    } block_ctrl_t;

    // One payload read as bytes or as control codes by header
    typedef union packed {
        logic [`PCS_BLOCK_WIDTH/8-1:0][7:0] octets;
        block_ctrl_t                        ctrl;
    } block_word_u;

    // Word passed between stages
    typedef struct packed {
        logic [`PCS_DATA_WIDTH-1:0] data;
        sync_header_t               header;
        logic                       header_valid;
        logic                       data_valid;
    } pcs_word_t;

endpackage

/* logic/rx_block_sync.sv */
`include "pcs_rx_macros.svh"

module rx_block_sync import pcs_rx_pkg::*; (
    input  logic      i_rxc,
    input  logic      i_reset,
    input  pcs_word_t i_word,
    output logic      o_block_lock
);

    localparam int WINDOW = 64;
    localparam int GOOD_W = $clog2(`PCS_LOCK_GOOD);
    localparam int BAD_W  = $clog2(`PCS_LOCK_BAD);
    localparam int WIN_W  = $clog2(WINDOW);

    logic             hdr_strobe;
    logic             hdr_ok;
    logic             locked_q;
    logic [GOOD_W-1:0] good_cnt_q;
    logic [BAD_W-1:0]  bad_cnt_q;
    logic [WIN_W-1:0]  win_cnt_q;

    assign hdr_strobe = i_word.data_valid && i_word.header_valid;
    // Only 01 and 10 are legal sync headers
    assign hdr_ok = (i_word.header == SYNC_DATA) || (i_word.header == SYNC_CTRL);

    always_ff @(posedge i_rxc) begin
        if (i_reset) begin
            locked_q   <= 1'b0;
            good_cnt_q <= '0;
            bad_cnt_q  <= '0;
            win_cnt_q  <= '0;
        end else if (hdr_strobe) begin
            if (!locked_q) begin
                // Hunting for an unbroken run of good headers
                if (!hdr_ok) begin
                    good_cnt_q <= '0;
                end else if (good_cnt_q == GOOD_W'(`PCS_LOCK_GOOD - 1)) begin
                    locked_q   <= 1'b1;
                    good_cnt_q <= '0;
                    bad_cnt_q  <= '0;
                    win_cnt_q  <= '0;
                end else begin
                    good_cnt_q <= good_cnt_q + 1'b1;
                end
            end else if (!hdr_ok && bad_cnt_q == BAD_W'(`PCS_LOCK_BAD - 1)) begin
                // Too many bad headers in this window so start hunting again
                locked_q  <= 1'b0;
                bad_cnt_q <= '0;
                win_cnt_q <= '0;
            end else if (win_cnt_q == WIN_W'(WINDOW - 1)) begin
                win_cnt_q <= '0;
                bad_cnt_q <= '0;
            end else begin
                win_cnt_q <= win_cnt_q + 1'b1;
                if (!hdr_ok) begin
                    bad_cnt_q <= bad_cnt_q + 1'b1;
                end
            end
        end
    end

    assign o_block_lock = locked_q;

    // Upstream must mark a header only on a valid word
    a_hdr_needs_data: assert property (@(posedge i_rxc) disable iff (i_reset)
        i_word.header_valid |-> i_word.data_valid)
        else $error("header valid without data valid");

endmodule

/* logic/rx_descrambler.sv */
`include "pcs_rx_macros.svh"

module rx_descrambler import pcs_rx_pkg::*; (
    input  logic      i_rxc,
    input  logic      i_reset,
    input  pcs_word_t i_word,
    output pcs_word_t o_word
);

    // x^58 + x^39 + 1 with the newest line bit at index 0
    localparam int SCR_LEN = 58;
    localparam int TAP_A   = 38;
    localparam int TAP_B   = 57;

    logic [SCR_LEN-1:0]         state_q;
    logic [SCR_LEN-1:0]         state_n;
    logic [`PCS_DATA_WIDTH-1:0] desc;
    logic [`PCS_DATA_WIDTH-1:0] data_q;
    sync_header_t               header_q;
    logic                       header_valid_q;
    logic                       data_valid_q;

    // Bit 0 is first on the line
    always_comb begin
        state_n = state_q;
        for (int i = 0; i < `PCS_DATA_WIDTH; i++) begin
            desc[i] = i_word.data[i] ^ state_n[TAP_A] ^ state_n[TAP_B];
            state_n = {state_n[SCR_LEN-2:0], i_word.data[i]};
        end
    end

    always_ff @(posedge i_rxc) begin
        if (i_reset) begin
            state_q        <= '0;
            header_valid_q <= 1'b0;
            data_valid_q   <= 1'b0;
        end else begin
            header_valid_q <= i_word.header_valid;
            data_valid_q   <= i_word.data_valid;
            if (i_word.data_valid) begin
                state_q <= state_n;
            end
        end
    end

    // Header is not scrambled and rides beside the data
    always_ff @(posedge i_rxc) begin
        if (i_word.data_valid) begin
            data_q   <= desc;
            header_q <= i_word.header;
        end
    end

    assign o_word = '{
        data:         data_q,
        header:       header_q,
        header_valid: header_valid_q,
        data_valid:   data_valid_q
    };

endmodule

/* logic/rx_decoder.sv */
`include "pcs_rx_macros.svh"

module rx_decoder import pcs_rx_pkg::*; (
    input  logic                         i_rxc,
    input  logic                         i_reset,
    input  pcs_word_t                    i_word,
    output logic [`PCS_DATA_WIDTH-1:0]   o_rxd,
    output logic [`PCS_DATA_WIDTH/8-1:0] o_rxctl,
    output logic                         o_rx_valid,
    output logic                         o_block_error
);

    localparam int LANES = `PCS_BLOCK_WIDTH / 8;
    localparam int HALF  = `PCS_DATA_WIDTH / 8;

    typedef struct packed {
        logic [`PCS_BLOCK_WIDTH-1:0] data;
        logic [LANES-1:0]            ctl;
        logic                        err;
    } xgmii_block_t;

    logic [`PCS_DATA_WIDTH-1:0] first_data_q;
    sync_header_t               first_hdr_q;
    logic                       have_first_q;
    logic                       hi_pending_q;
    logic [`PCS_DATA_WIDTH-1:0] hi_rxd_q;
    logic [HALF-1:0]            hi_rxctl_q;
    logic                       first_word;
    logic                       second_word;
    block_word_u                blk;
    xgmii_block_t               dec;

    // Replace masked lanes with their control characters
    function automatic logic [`PCS_BLOCK_WIDTH-1:0] code_lanes(
        input block_word_u      b,
        input logic [LANES-1:0] mask
    );
        logic [`PCS_BLOCK_WIDTH-1:0] res;
        res = b.octets;
        for (int i = 0; i < LANES; i++) begin
            if (mask[i]) begin
                res[8*i +: 8] = control_to_rs_code(b.ctrl.codes[i]);
            end
        end
        return res;
    endfunction

    // Terminate in lane n with data below and control codes above
    function automatic xgmii_block_t decode_term(input block_word_u b, input logic [2:0] n);
        xgmii_block_t                res;
        logic [`PCS_BLOCK_WIDTH-1:0] shifted;
        shifted = b.octets >> 8;
        res.err = 1'b0;
        res.ctl = {LANES{1'b1}} << n;
        for (int k = 0; k < LANES; k++) begin
            if (k < int'(n)) begin
                res.data[8*k +: 8] = shifted[8*k +: 8];
            end else if (k == int'(n)) begin
                res.data[8*k +: 8] = RS_TERM;
            end else begin
                res.data[8*k +: 8] = control_to_rs_code(b.ctrl.codes[k]);
            end
        end
        return res;
    endfunction

    function automatic xgmii_block_t decode_block(input block_word_u b, input sync_header_t hdr);
        xgmii_block_t res;
        logic         bad;
        res.data = b.octets;
        res.ctl  = '0;
        res.err  = 1'b0;
        // An illegal header is treated like an unknown block
        bad = (hdr != SYNC_DATA) && (hdr != SYNC_CTRL);
        if (hdr == SYNC_CTRL) begin
            case (b.ctrl.btype)
                BT_IDLE: begin
                    res.data = code_lanes(b, 8'hFF);
                    res.ctl  = 8'hFF;
                end
                BT_O4: begin
                    res.data          = code_lanes(b, 8'h0F);
                    res.data[39:32]   = cc_to_rs_ocode(b.octets[4][7:4]);
                    res.ctl           = 8'h1F;
                end
                BT_S4: begin
                    res.data        = code_lanes(b, 8'h0F);
                    res.data[39:32] = RS_START;
                    res.ctl         = 8'h1F;
                end
                BT_O0S4: begin
                    res.data[39:32] = RS_START;
                    res.data[7:0]   = cc_to_rs_ocode(b.octets[4][3:0]);
                    res.ctl         = 8'h11;
                end
                BT_O0O4: begin
                    res.data[39:32] = cc_to_rs_ocode(b.octets[4][7:4]);
                    res.data[7:0]   = cc_to_rs_ocode(b.octets[4][3:0]);
                    res.ctl         = 8'h11;
                end
                BT_S0: begin
                    res.data[7:0] = RS_START;
                    res.ctl       = 8'h01;
                end
                BT_O0: begin
                    res.data      = code_lanes(b, 8'hF0);
                    res.data[7:0] = cc_to_rs_ocode(b.octets[4][3:0]);
                    res.ctl       = 8'hF1;
                end
                BT_T0: res = decode_term(b, 3'd0);
                BT_T1: res = decode_term(b, 3'd1);
                BT_T2: res = decode_term(b, 3'd2);
                BT_T3: res = decode_term(b, 3'd3);
                BT_T4: res = decode_term(b, 3'd4);
                BT_T5: res = decode_term(b, 3'd5);
                BT_T6: res = decode_term(b, 3'd6);
                BT_T7: res = decode_term(b, 3'd7);
                default: bad = 1'b1;
            endcase
        end
        if (bad) begin
            res.data = {LANES{RS_ERROR}};
            res.ctl  = '1;
            res.err  = 1'b1;
        end
        return res;
    endfunction

    assign first_word  = i_word.data_valid && i_word.header_valid;
    assign second_word = i_word.data_valid && !i_word.header_valid && have_first_q;

    // Low half comes first on the line
    assign blk = {i_word.data, first_data_q};
    assign dec = decode_block(blk, first_hdr_q);

    always_ff @(posedge i_rxc) begin
        if (first_word) begin
            first_data_q <= i_word.data;
            first_hdr_q  <= i_word.header;
        end
    end

    always_ff @(posedge i_rxc) begin
        if (i_reset) begin
            have_first_q <= 1'b0;
            hi_pending_q <= 1'b0;
            hi_rxd_q     <= '0;
            hi_rxctl_q   <= '0;
        end else if (i_word.data_valid) begin
            have_first_q <= i_word.header_valid;
            hi_pending_q <= second_word;
            if (second_word) begin
                hi_rxd_q   <= dec.data[`PCS_BLOCK_WIDTH-1:`PCS_DATA_WIDTH];
                hi_rxctl_q <= dec.ctl[LANES-1:HALF];
            end
        end
    end

    // Low half straight through and high half on the next valid cycle
    assign o_rx_valid    = second_word || (i_word.data_valid && hi_pending_q);
    assign o_rxd         = second_word ? dec.data[`PCS_DATA_WIDTH-1:0] : hi_rxd_q;
    assign o_rxctl       = second_word ? dec.ctl[HALF-1:0] : hi_rxctl_q;
    assign o_block_error = second_word && dec.err;

    // A new block must not start before the previous one got its second word
    a_no_double_hdr: assert property (@(posedge i_rxc) disable iff (i_reset)
        first_word |-> !have_first_q)
        else $error("two header words in a row");

endmodule

/* logic/pcs_rx_top.sv */
`include "pcs_rx_macros.svh"

module pcs_rx_top import pcs_rx_pkg::*; (
    input  logic                         i_rxc,
    input  logic                         i_reset,
    input  logic [`PCS_DATA_WIDTH-1:0]   i_rxd,
    input  logic [1:0]                   i_rx_header,
    input  logic                         i_rx_data_valid,
    input  logic                         i_rx_header_valid,
    output logic [`PCS_DATA_WIDTH-1:0]   o_rxd,
    output logic [`PCS_DATA_WIDTH/8-1:0] o_rxctl,
    output logic                         o_rx_valid,
    output logic                         o_block_error,
    output logic                         o_block_lock
);

    pcs_word_t line_word;
    pcs_word_t desc_word;

    assign line_word = '{
        data:         i_rxd,
        header:       i_rx_header,
        header_valid: i_rx_header_valid,
        data_valid:   i_rx_data_valid
    };

    // Lock is judged on the raw headers
    rx_block_sync u_block_sync (
        .i_rxc        (i_rxc),
        .i_reset      (i_reset),
        .i_word       (line_word),
        .o_block_lock (o_block_lock)
    );

    rx_descrambler u_descrambler (
        .i_rxc   (i_rxc),
        .i_reset (i_reset),
        .i_word  (line_word),
        .o_word  (desc_word)
    );

    rx_decoder u_decoder (
        .i_rxc         (i_rxc),
        .i_reset       (i_reset),
        .i_word        (desc_word),
        .o_rxd         (o_rxd),
        .o_rxctl       (o_rxctl),
        .o_rx_valid    (o_rx_valid),
        .o_block_error (o_block_error)
    );

endmodule

/* verif/pcs_rx_tb.sv */
`include "pcs_rx_macros.svh"

module pcs_rx_tb import pcs_rx_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 20;

    // One table row is one 66-bit block and its decoded XGMII result
    typedef struct packed {
        sync_header_t  hdr;
        block_word_u   pay;
        logic [63:0]   data;
        logic [7:0]    ctl;
        logic          err;
    } entry_t;

    logic                         i_rxc;
    logic                         i_reset;
    logic [`PCS_DATA_WIDTH-1:0]   i_rxd;
    logic [1:0]                   i_rx_header;
    logic                         i_rx_data_valid;
    logic                         i_rx_header_valid;
    logic [`PCS_DATA_WIDTH-1:0]   o_rxd;
    logic [`PCS_DATA_WIDTH/8-1:0] o_rxctl;
    logic                         o_rx_valid;
    logic                         o_block_error;
    logic                         o_block_lock;

    entry_t      table_q[$];
    logic        table_ready = 1'b0;
    logic [57:0] scr_state = '0;
    int          errors = 0;
    int          pass_cnt = 0;
    int          out_idx = 0;
    logic        half_sel = 1'b0;
    logic [31:0] lo_data;
    logic [3:0]  lo_ctl;
    logic        lo_err;
    logic        exp_lock = 1'b0;
    int          run_good = 0;
    int          bad_seen = 0;

    pcs_rx_top dut (.*);

    initial begin
        i_rxc = 1'b0;
        forever #(CLK_PERIOD / 2) i_rxc = ~i_rxc;
    end

    task automatic add_entry(input sync_header_t hdr, input block_word_u pay,
                             input logic [63:0] data, input logic [7:0] ctl, input logic err);
        table_q.push_back('{hdr: hdr, pay: pay, data: data, ctl: ctl, err: err});
    endtask

    // Control block from its type and the 56 bits above it
    task automatic add_ctrl(input block_type_t bt, input logic [55:0] rest,
                            input logic [63:0] data, input logic [7:0] ctl);
        block_word_u w;
        w.ctrl.btype  = bt;
        w.octets[7:1] = rest;
        add_entry(SYNC_CTRL, w, data, ctl, 1'b0);
    endtask

    task automatic build_table();
        block_word_u w;
        logic [55:0] rest;
        logic [63:0] exp;
        block_type_t term_bt [8];
        term_bt = '{BT_T0, BT_T1, BT_T2, BT_T3, BT_T4, BT_T5, BT_T6, BT_T7};
        w.octets = 64'h0123_4567_89AB_CDEF;
        add_entry(SYNC_DATA, w, 64'h0123_4567_89AB_CDEF, 8'h00, 1'b0);
        add_ctrl(BT_IDLE, 56'h0, 64'h0707_0707_0707_0707, 8'hFF);
        add_ctrl(BT_O4, 56'h33_2211_0000_0000, 64'h3322_119C_0707_0707, 8'h1F);
        add_ctrl(BT_S4, 56'h66_5544_0000_0000, 64'h6655_44FB_0707_0707, 8'h1F);
        add_ctrl(BT_O0S4, 56'hCC_BBAA_0033_2211, 64'hCCBB_AAFB_3322_119C, 8'h11);
        add_ctrl(BT_O0O4, 56'h77_6655_0044_3322, 64'h7766_559C_4433_229C, 8'h11);
        add_ctrl(BT_S0, 56'hDE_ADBE_EFCA_FE01, 64'hDEAD_BEEF_CAFE_01FB, 8'h01);
        add_ctrl(BT_O0, 56'h00_0000_005A_5A5A, 64'h0707_0707_5A5A_5A9C, 8'hF1);
        // Terminate in lane n with data below and idle above
        for (int n = 0; n < 8; n++) begin
            rest = '0;
            exp  = {8{RS_IDLE}};
            for (int k = 0; k < n; k++) begin
                rest[8*k +: 8] = 8'(8'hA0 + k);
                exp[8*k +: 8]  = 8'(8'hA0 + k);
            end
            exp[8*n +: 8] = RS_TERM;
            add_ctrl(term_bt[n], rest, exp, 8'hFF << n);
        end
        w.ctrl.btype  = block_type_t'(8'h00);
        w.octets[7:1] = 56'h12_3456_789A_BCDE;
        add_entry(SYNC_CTRL, w, {8{RS_ERROR}}, 8'hFF, 1'b1);
        // Filler so that lock is reached
        repeat (49) begin
            w.octets = {$urandom, $urandom};
            add_entry(SYNC_DATA, w, w.octets, 8'h00, 1'b0);
        end
        // Illegal headers 00 and 11 to drop lock again
        for (int i = 0; i < `PCS_LOCK_BAD; i++) begin
            w.octets = {$urandom, $urandom};
            add_entry(i[0] ? 2'b11 : 2'b00, w, {8{RS_ERROR}}, 8'hFF, 1'b1);
        end
    endtask

    // Line scrambler x^58 + x^39 + 1 with bit 0 sent first
    task automatic scramble_word(input logic [31:0] d, output logic [31:0] s);
        for (int i = 0; i < 32; i++) begin
            s[i]      = d[i] ^ scr_state[38] ^ scr_state[57];
            scr_state = {scr_state[56:0], s[i]};
        end
    endtask

    task automatic send_word(input logic [31:0] data, input logic [1:0] hdr, input logic first);
        repeat ($urandom_range(2)) begin
            @(posedge i_rxc);
            i_rx_data_valid   <= 1'b0;
            i_rx_header_valid <= 1'b0;
        end
        @(posedge i_rxc);
        i_rxd             <= data;
        i_rx_header       <= hdr;
        i_rx_data_valid   <= 1'b1;
        i_rx_header_valid <= first;
    endtask

    // Expected lock while the bad headers fall in one window
    task automatic update_lock_model(input logic [1:0] hdr);
        logic ok;
        ok = (hdr == SYNC_DATA) || (hdr == SYNC_CTRL);
        if (!exp_lock) begin
            run_good = ok ? run_good + 1 : 0;
            if (run_good == `PCS_LOCK_GOOD) begin
                exp_lock = 1'b1;
                bad_seen = 0;
            end
        end else if (!ok) begin
            bad_seen++;
            if (bad_seen == `PCS_LOCK_BAD) begin
                exp_lock = 1'b0;
                run_good = 0;
            end
        end
    endtask

    task automatic check_lock();
        if (o_block_lock !== exp_lock) begin
            errors++;
            $display("Mismatch at %0t: block lock %b, expected %b", $time, o_block_lock, exp_lock);
        end
    endtask

    task automatic check_block(input logic [63:0] data, input logic [7:0] ctl, input logic err);
        entry_t e;
        if (out_idx >= table_q.size()) begin
            errors++;
            $display("Unexpected extra output block at %0t", $time);
        end else begin
            e = table_q[out_idx];
            if (data !== e.data || ctl !== e.ctl || err !== e.err) begin
                errors++;
                $display("Mismatch at %0t: block %0d got %h/%h/%b, expected %h/%h/%b", $time,
                         out_idx, data, ctl, err, e.data, e.ctl, e.err);
                $display("Block %0d: FAIL", out_idx);
            end else begin
                pass_cnt++;
                $display("Block %0d: pass", out_idx);
            end
            out_idx++;
        end
    endtask

    // Outputs settle well before the falling edge
    always @(negedge i_rxc) begin
        if (!i_reset && o_rx_valid) begin
            if (!half_sel) begin
                lo_data  = o_rxd;
                lo_ctl   = o_rxctl;
                lo_err   = o_block_error;
                half_sel = 1'b1;
            end else begin
                half_sel = 1'b0;
                // Block error belongs to the low half only
                if (o_block_error !== 1'b0) begin
                    errors++;
                    $display("Mismatch at %0t: block error raised with the high half", $time);
                end
                check_block({o_rxd, lo_data}, {o_rxctl, lo_ctl}, lo_err);
            end
        end
    end

    initial begin
        wait (table_ready);
        #(table_q.size() * 100 * CLK_PERIOD);
        $display("Timeout: only %0d of %0d blocks were decoded", out_idx, table_q.size());
        $display("Test failed");
        $finish;
    end

    initial begin
        entry_t      ent;
        logic [31:0] s_lo;
        logic [31:0] s_hi;
        i_reset           <= 1'b1;
        i_rxd             <= '0;
        i_rx_header       <= 2'b00;
        i_rx_data_valid   <= 1'b0;
        i_rx_header_valid <= 1'b0;
        void'($urandom(32'hce45));
        build_table();
        table_ready = 1'b1;
        repeat (10) @(posedge i_rxc);
        i_reset <= 1'b0;
        for (int i = 0; i < table_q.size(); i++) begin
            ent = table_q[i];
            @(negedge i_rxc);
            check_lock();
            scramble_word(ent.pay.octets[3:0], s_lo);
            scramble_word(ent.pay.octets[7:4], s_hi);
            send_word(s_lo, ent.hdr, 1'b1);
            send_word(s_hi, 2'b00, 1'b0);
            update_lock_model(ent.hdr);
        end
        // A lone data word pushes out the last high half
        send_word('0, 2'b00, 1'b0);
        @(posedge i_rxc);
        i_rx_data_valid <= 1'b0;
        wait (out_idx == table_q.size());
        repeat (3) @(negedge i_rxc);
        check_lock();
        $display("%0d blocks checked, %0d passed, %0d errors", out_idx, pass_cnt, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* files.f */
+incdir+include
logic/pcs_rx_pkg.sv
logic/rx_block_sync.sv
logic/rx_descrambler.sv
logic/rx_decoder.sv
logic/pcs_rx_top.sv
verif/pcs_rx_tb.sv
